// File: hdl/v_fltr_config.svh
`ifndef V_FLTR_CONFIG_SVH
`define V_FLTR_CONFIG_SVH

// datapath widths
`define V_FLTR_PIXEL_W      8
`define V_FLTR_COEF_W       9
`define V_FLTR_PROD_W       17
`define V_FLTR_SUM_W        20
`define V_FLTR_OUT_W        16
`define V_FLTR_OUT_SHIFT    3

// window geometry, taps spaced in strobes
`define V_FLTR_TAPS         7
`define V_FLTR_TAP_SPACING  3

// coefficients c0..c3, taps 4..6 mirror taps 2..0
`define V_FLTR_F1_C0  29
`define V_FLTR_F1_C1  101
`define V_FLTR_F1_C2  17
`define V_FLTR_F1_C3  277
`define V_FLTR_F2_C0  4
`define V_FLTR_F2_C1  42
`define V_FLTR_F2_C2  163
`define V_FLTR_F2_C3  255
`define V_FLTR_F3_C0  20
`define V_FLTR_F3_C1  179
`define V_FLTR_F3_C2  364
`define V_FLTR_F3_C3  0

// edge and band set
`define V_FLTR_H1_C0  17
`define V_FLTR_H1_C1  25
`define V_FLTR_H1_C2  193
`define V_FLTR_H1_C3  0
`define V_FLTR_H2_C0  4
`define V_FLTR_H2_C1  42
`define V_FLTR_H2_C2  163
`define V_FLTR_H2_C3  255
`define V_FLTR_H3_C0  23
`define V_FLTR_H3_C1  72
`define V_FLTR_H3_C2  147
`define V_FLTR_H3_C3  0
`define V_FLTR_H4_C0  14
`define V_FLTR_H4_C1  43
`define V_FLTR_H4_C2  80
`define V_FLTR_H4_C3  324

`endif

// File: hdl/v_fltr_pkg.sv
`include "v_fltr_config.svh"

package v_fltr_pkg;

   typedef logic [`V_FLTR_PIXEL_W-1:0] pixel_t;
   typedef logic [`V_FLTR_COEF_W-1:0]  coef_t;
   typedef logic [`V_FLTR_PROD_W-1:0]  prod_t;
   typedef logic [`V_FLTR_OUT_W-1:0]   result_t;

   // tap0 is the newest pixel, tap6 the oldest
   typedef struct packed {
      pixel_t tap0;
      pixel_t tap1;
      pixel_t tap2;
      pixel_t tap3;
      pixel_t tap4;
      pixel_t tap5;
      pixel_t tap6;
   } tap_window_t;

   typedef struct packed {
      coef_t c0;
      coef_t c1;
      coef_t c2;
      coef_t c3;
      coef_t c4;
      coef_t c5;
      coef_t c6;
   } coef_set_t;

   typedef struct packed {
      prod_t p0;
      prod_t p1;
      prod_t p2;
      prod_t p3;
      prod_t p4;
      prod_t p5;
      prod_t p6;
   } product_set_t;

   typedef enum logic [2:0] {
      FILT_F1,
      FILT_F2,
      FILT_F3,
      FILT_H1,
      FILT_H2,
      FILT_H3,
      FILT_H4
   } filt_id_e;

   localparam int NUM_FILTERS = 7;

   // symmetric set from its first four coefficients
   function automatic coef_set_t mirror_set(input coef_t c0, input coef_t c1,
                                            input coef_t c2, input coef_t c3);
      return '{c0: c0, c1: c1, c2: c2, c3: c3, c4: c2, c5: c1, c6: c0};
   endfunction

   function automatic coef_set_t coef_for(input filt_id_e id);
      case (id)
         FILT_F1: return mirror_set(`V_FLTR_F1_C0, `V_FLTR_F1_C1, `V_FLTR_F1_C2, `V_FLTR_F1_C3);
         FILT_F2: return mirror_set(`V_FLTR_F2_C0, `V_FLTR_F2_C1, `V_FLTR_F2_C2, `V_FLTR_F2_C3);
         FILT_F3: return mirror_set(`V_FLTR_F3_C0, `V_FLTR_F3_C1, `V_FLTR_F3_C2, `V_FLTR_F3_C3);
         FILT_H1: return mirror_set(`V_FLTR_H1_C0, `V_FLTR_H1_C1, `V_FLTR_H1_C2, `V_FLTR_H1_C3);
         FILT_H2: return mirror_set(`V_FLTR_H2_C0, `V_FLTR_H2_C1, `V_FLTR_H2_C2, `V_FLTR_H2_C3);
         FILT_H3: return mirror_set(`V_FLTR_H3_C0, `V_FLTR_H3_C1, `V_FLTR_H3_C2, `V_FLTR_H3_C3);
         FILT_H4: return mirror_set(`V_FLTR_H4_C0, `V_FLTR_H4_C1, `V_FLTR_H4_C2, `V_FLTR_H4_C3);
         default: return '0;
      endcase
   endfunction

endpackage

// File: hdl/line_delay_chain.sv
`include "v_fltr_config.svh"

module line_delay_chain
   import v_fltr_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        new_data,
   input  pixel_t      pixel_in,
   output tap_window_t window
);

   localparam int GROUPS = `V_FLTR_TAPS - 1;
   localparam int DEPTH  = `V_FLTR_TAP_SPACING;

   pixel_t tap0;
   // one group of spacing registers between adjacent taps
   pixel_t grp [GROUPS][DEPTH];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tap0 <= '0;
         for (int g = 0; g < GROUPS; g++)
         begin
            for (int s = 0; s < DEPTH; s++)
            begin
               grp[g][s] <= '0;
            end
         end
      end
      else if (new_data)
      begin
         tap0 <= pixel_in;
         for (int g = 0; g < GROUPS; g++)
         begin
            // each group is fed by the last stage of the one before
            grp[g][0] <= (g == 0) ? tap0 : grp[g-1][DEPTH-1];
            for (int s = 1; s < DEPTH; s++)
            begin
               grp[g][s] <= grp[g][s-1];
            end
         end
      end
   end

   // tap k sits at the end of group k-1
   assign window = '{
      tap0: tap0,
      tap1: grp[0][DEPTH-1],
      tap2: grp[1][DEPTH-1],
      tap3: grp[2][DEPTH-1],
      tap4: grp[3][DEPTH-1],
      tap5: grp[4][DEPTH-1],
      tap6: grp[5][DEPTH-1]
   };

endmodule

// File: hdl/tap_multiplier.sv
`include "v_fltr_config.svh"

module tap_multiplier
   import v_fltr_pkg::*;
#(
   parameter filt_id_e filt = FILT_F1
)
(
   input  logic         clk,
   input  logic         reset,
   input  tap_window_t  window,
   output product_set_t products
);

   localparam coef_set_t COEFS = coef_for(filt);

   pixel_t taps  [`V_FLTR_TAPS];
   coef_t  coefs [`V_FLTR_TAPS];
   prod_t  prod_next [`V_FLTR_TAPS];

   assign taps  = '{window.tap0, window.tap1, window.tap2, window.tap3,
                    window.tap4, window.tap5, window.tap6};
   assign coefs = '{COEFS.c0, COEFS.c1, COEFS.c2, COEFS.c3,
                    COEFS.c4, COEFS.c5, COEFS.c6};

   // unsigned products, 255 x 511 still fits the product width
   always_comb
   begin
      for (int k = 0; k < `V_FLTR_TAPS; k++)
      begin
         prod_next[k] = `V_FLTR_PROD_W'(taps[k]) * `V_FLTR_PROD_W'(coefs[k]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         products <= '0;
      else
         products <= {prod_next[0], prod_next[1], prod_next[2], prod_next[3],
                      prod_next[4], prod_next[5], prod_next[6]};
   end

endmodule

// File: hdl/tap_accumulator.sv
`include "v_fltr_config.svh"

module tap_accumulator
   import v_fltr_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  product_set_t products,
   output result_t      result
);

   prod_t                   prods [`V_FLTR_TAPS];
   logic [`V_FLTR_SUM_W-1:0] sum_next;
   logic [`V_FLTR_SUM_W-1:0] sum;

   assign prods = '{products.p0, products.p1, products.p2, products.p3,
                    products.p4, products.p5, products.p6};

   // zero extended adder tree
   always_comb
   begin
      sum_next = '0;
      for (int k = 0; k < `V_FLTR_TAPS; k++)
      begin
         sum_next = sum_next + `V_FLTR_SUM_W'(prods[k]);
      end
   end

   // stage 2 holds the sum
   always_ff @(posedge clk)
   begin
      if (reset)
         sum <= '0;
      else
         sum <= sum_next;
   end

   // stage 3, drop the low bits and keep the output width
   always_ff @(posedge clk)
   begin
      if (reset)
         result <= '0;
      else
         result <= sum[`V_FLTR_OUT_SHIFT + `V_FLTR_OUT_W - 1 : `V_FLTR_OUT_SHIFT];
   end

endmodule

// File: hdl/v_fltr_bank.sv
module v_fltr_bank
   import v_fltr_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    new_data,
   input  pixel_t  pixel_in,
   output result_t out_f1,
   output result_t out_f2,
   output result_t out_f3,
   output result_t out_h1,
   output result_t out_h2,
   output result_t out_h3,
   output result_t out_h4
);

   tap_window_t  window;
   product_set_t products [NUM_FILTERS];
   result_t      results  [NUM_FILTERS];

   // shared tap window for the whole bank
   line_delay_chain u_chain (
      .clk      (clk),
      .reset    (reset),
      .new_data (new_data),
      .pixel_in (pixel_in),
      .window   (window)
   );

   // one multiply and accumulate pipe per filter id
   for (genvar i = 0; i < NUM_FILTERS; i++)
   begin : g_filter
      localparam filt_id_e FID = filt_id_e'(i);

      tap_multiplier #(
         .filt (FID)
      ) u_mult (
         .clk      (clk),
         .reset    (reset),
         .window   (window),
         .products (products[i])
      );

      tap_accumulator u_acc (
         .clk      (clk),
         .reset    (reset),
         .products (products[i]),
         .result   (results[i])
      );
   end

   // smoothing set
   assign out_f1 = results[FILT_F1];
   assign out_f2 = results[FILT_F2];
   assign out_f3 = results[FILT_F3];

   // edge and band set
   assign out_h1 = results[FILT_H1];
   assign out_h2 = results[FILT_H2];
   assign out_h3 = results[FILT_H3];
   assign out_h4 = results[FILT_H4];

endmodule

// File: sim/v_fltr_bank_tb.sv
`include "v_fltr_config.svh"

module v_fltr_bank_tb
   import v_fltr_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   // one drive edge plus three pipeline stages
   localparam int LAG = 4;
   localparam int CLK_PERIOD = 40;

   typedef struct packed {
      logic [7:0]                          test;
      logic                                rst;
      logic                                nd;
      pixel_t                              px;
      logic [6:0][`V_FLTR_OUT_W-1:0]       res;
   } vector_t;

   logic    clk;
   logic    reset;
   logic    new_data;
   pixel_t  pixel_in;
   result_t out_f1;
   result_t out_f2;
   result_t out_f3;
   result_t out_h1;
   result_t out_h2;
   result_t out_h3;
   result_t out_h4;

   vector_t vecs [$];
   vector_t pending [$];
   string   port_names [7] = '{"out_f1", "out_f2", "out_f3", "out_h1",
                               "out_h2", "out_h3", "out_h4"};

   int      total_checks;
   int      total_errors;
   int      tests_done;
   int      cur_test;
   int      cur_checks;
   int      cur_errors;
   bit      load_ok;
   bit      armed;
   longint  limit_ns;

   v_fltr_bank dut (
      .clk      (clk),
      .reset    (reset),
      .new_data (new_data),
      .pixel_in (pixel_in),
      .out_f1   (out_f1),
      .out_f2   (out_f2),
      .out_f3   (out_f3),
      .out_h1   (out_h1),
      .out_h2   (out_h2),
      .out_h3   (out_h3),
      .out_h4   (out_h4)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic load_vectors(output bit ok);
      int      fd;
      int      n;
      int      t;
      int      r;
      int      d;
      int      p;
      int      e [7];
      string   line;
      vector_t v;
      ok = 1;
      fd = $fopen("sim/v_fltr_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the vector file sim/v_fltr_vectors.txt");
         ok = 0;
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", t, r, d, p,
                     e[0], e[1], e[2], e[3], e[4], e[5], e[6]);
         if (n != 11)
         begin
            $display("could not parse vector line: %s", line);
            ok = 0;
         end
         else
         begin
            v.test = t[7:0];
            v.rst  = r[0];
            v.nd   = d[0];
            v.px   = p[7:0];
            for (int k = 0; k < 7; k++)
               v.res[k] = e[k][`V_FLTR_OUT_W-1:0];
            vecs.push_back(v);
         end
      end
      $fclose(fd);
      if (vecs.size() == 0)
      begin
         $display("the vector file holds no vector lines");
         ok = 0;
      end
   endtask

   task automatic close_test();
      $display("test %0d done: %0d checks, %0d errors, %s", cur_test, cur_checks,
               cur_errors, (cur_errors == 0) ? "ok" : "failing");
      tests_done++;
      cur_checks = 0;
      cur_errors = 0;
   endtask

   task automatic compare_outputs(input vector_t exp);
      result_t act [7];
      act = '{out_f1, out_f2, out_f3, out_h1, out_h2, out_h3, out_h4};
      if (cur_test >= 0 && int'(exp.test) != cur_test)
         close_test();
      cur_test = exp.test;
      for (int k = 0; k < 7; k++)
      begin
         total_checks++;
         cur_checks++;
         if (act[k] !== exp.res[k])
         begin
            $display("MISMATCH test %0d %s expected 0x%04h actual 0x%04h",
                     exp.test, port_names[k], exp.res[k], act[k]);
            total_errors++;
            cur_errors++;
         end
      end
   endtask

   // hold the window and check every result still in the pipe
   task automatic drain_pending();
      int idle;
      idle = LAG - pending.size();
      while (pending.size() > 0)
      begin
         @(posedge clk);
         reset    <= 1'b0;
         new_data <= 1'b0;
         @(negedge clk);
         if (idle > 0)
            idle--;
         else
            compare_outputs(pending.pop_front());
      end
   endtask

   task automatic run_vectors();
      foreach (vecs[i])
      begin
         // let the pipe empty before a reset clears it
         if (vecs[i].rst)
            drain_pending();
         @(posedge clk);
         reset    <= vecs[i].rst;
         new_data <= vecs[i].nd;
         pixel_in <= vecs[i].px;
         pending.push_back(vecs[i]);
         @(negedge clk);
         if (pending.size() > LAG)
            compare_outputs(pending.pop_front());
      end
      // drain the last lines with the window held
      drain_pending();
      if (cur_test >= 0)
         close_test();
   endtask

   initial
   begin
      clk          = 1'b0;
      reset        = 1'b1;
      new_data     = 1'b0;
      pixel_in     = '0;
      total_checks = 0;
      total_errors = 0;
      tests_done   = 0;
      cur_test     = -1;
      cur_checks   = 0;
      cur_errors   = 0;
      armed        = 0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      load_vectors(load_ok);
      limit_ns = (longint'(vecs.size()) + 20) * CLK_PERIOD;
      armed = 1;
      if (load_ok)
         run_vectors();
      $display("tests %0d, checks %0d, errors %0d", tests_done, total_checks,
               total_errors);
      if (load_ok && total_errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // watchdog scaled to the number of vector lines
   initial
   begin
      wait (armed);
      #(limit_ns);
      $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: v_fltr_bank.f
+incdir+hdl
hdl/v_fltr_pkg.sv
hdl/line_delay_chain.sv
hdl/tap_multiplier.sv
hdl/tap_accumulator.sv
hdl/v_fltr_bank.sv
sim/v_fltr_bank_tb.sv

// File: Makefile
SIM_BIN = v_fltr_sim

.PHONY: sim clean

sim:
	verilator --binary --timing -f v_fltr_bank.f --top-module v_fltr_bank_tb -o $(SIM_BIN)
	./obj_dir/$(SIM_BIN) | tee /dev/stderr | grep -q -x "TB PASSED"

clean:
	rm -rf obj_dir

// File: sim/v_fltr_vectors.txt
# columns: test reset new_data pixel_in then expected f1 f2 f3 h1 h2 h3 h4, all hex
# expected values show three cycles after the line is sampled, reset drops those in flight
# test 1: idle after reset
1 0 0 00 0000 0000 0000 0000 0000 0000 0000
1 0 0 00 0000 0000 0000 0000 0000 0000 0000
1 0 0 00 0000 0000 0000 0000 0000 0000 0000
# test 2: impulse of 8 walks through the taps
2 0 1 08 001D 0004 0014 0011 0004 0017 000E
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0065 002A 00B3 0019 002A 0048 002B
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0011 00A3 016C 00C1 00A3 0093 0050
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0115 00FF 0000 0000 00FF 0000 0144
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0011 00A3 016C 00C1 00A3 0093 0050
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0065 002A 00B3 0019 002A 0048 002B
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 0000 0000 0000 0000 0000 0000 0000
2 0 1 00 001D 0004 0014 0011 0004 0017 000E
# test 3: hold without strobes, pixel changes ignored
3 0 0 5A 001D 0004 0014 0011 0004 0017 000E
3 0 0 A5 001D 0004 0014 0011 0004 0017 000E
3 0 0 FF 001D 0004 0014 0011 0004 0017 000E
3 0 0 01 001D 0004 0014 0011 0004 0017 000E
# test 4: full scale run of 255
4 0 1 FF 039C 007F 027D 021D 007F 02DD 01BE
4 0 1 FF 039C 007F 027D 021D 007F 02DD 01BE
4 0 1 FF 039C 007F 027D 021D 007F 02DD 01BE
4 0 1 FF 102F 05BA 18C7 053A 05BA 0BD4 0718
4 0 1 FF 102F 05BA 18C7 053A 05BA 0BD4 0718
4 0 1 FF 102F 05BA 18C7 053A 05BA 0BD4 0718
4 0 1 FF 124D 1A05 4619 1D42 1A05 1E21 110E
4 0 1 FF 124D 1A05 4619 1D42 1A05 1E21 110E
4 0 1 FF 124D 1A05 4619 1D42 1A05 1E21 110E
4 0 1 FF 34CB 39C6 4619 1D42 39C6 1E21 3966
4 0 1 FF 34CB 39C6 4619 1D42 39C6 1E21 3966
4 0 1 FF 34CB 39C6 4619 1D42 39C6 1E21 3966
4 0 1 FF 36E8 4E11 736C 354A 4E11 306F 435C
4 0 1 FF 36E8 4E11 736C 354A 4E11 306F 435C
4 0 1 FF 36E8 4E11 736C 354A 4E11 306F 435C
4 0 1 FF 437C 534C 89B5 3867 534C 3966 48B7
4 0 1 FF 437C 534C 89B5 3867 534C 3966 48B7
4 0 1 FF 437C 534C 89B5 3867 534C 3966 48B7
4 0 1 FF 4718 53CB 8C33 3A85 53CB 3C43 4A75
4 0 1 FF 4718 53CB 8C33 3A85 53CB 3C43 4A75
4 0 1 FF 4718 53CB 8C33 3A85 53CB 3C43 4A75
# test 5: reset, back to back ramp 0 to 40, then sparse strobes
5 1 0 00 0000 0000 0000 0000 0000 0000 0000
5 0 1 00 0000 0000 0000 0000 0000 0000 0000
5 0 1 08 001D 0004 0014 0011 0004 0017 000E
5 0 1 10 003A 0008 0028 0022 0008 002E 001C
5 0 1 18 0057 000C 003C 0033 000C 0045 002A
5 0 1 20 00D9 003A 0103 005D 003A 00A4 0063
5 0 1 28 015B 0068 01CA 0087 0068 0103 009C
5 0 0 FF 015B 0068 01CA 0087 0068 0103 009C
5 0 1 00 012F 007E 0219 004B 007E 00D8 0081
5 0 0 33 012F 007E 0219 004B 007E 00D8 0081
5 0 1 00 01A5 014B 0438 0125 014B 01B3 00FC
5 0 0 C3 01A5 014B 0438 0125 014B 01B3 00FC
5 0 1 00 021B 0218 0657 01FF 0218 028E 0177
5 0 0 7E 021B 0218 0657 01FF 0218 028E 0177
5 0 1 00 0033 01E9 0444 0243 01E9 01B9 00F0
# test 6: mid-stream reset, then fresh data on a zeroed history
6 1 0 00 0000 0000 0000 0000 0000 0000 0000
6 0 0 00 0000 0000 0000 0000 0000 0000 0000
6 0 1 08 001D 0004 0014 0011 0004 0017 000E
6 0 1 00 0000 0000 0000 0000 0000 0000 0000
6 0 1 00 0000 0000 0000 0000 0000 0000 0000
6 0 1 00 0065 002A 00B3 0019 002A 0048 002B
6 0 0 00 0065 002A 00B3 0019 002A 0048 002B
6 0 0 00 0065 002A 00B3 0019 002A 0048 002B
